// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tetromino_control
FILELIST  ?= tetromino_control.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_tetromino_control.sv ====
// testbench for the falling piece control core
// button stimulus, reference pose model, pose assertions and report
`timescale 1ns/100ps

module tb_tetromino_control
    import piece_pkg::*;
();
    localparam int COOLDOWN       = 16;
    localparam int HOLD_CYCLES    = 3;
    localparam int IDLE_CYCLES    = 20;
    // about 35 presses of 24 cycles plus the long holds and a wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int SPAWN_ROW      = 0;
    localparam int SPAWN_COL      = 3;

    // active low bit positions in keys
    localparam int KEY_LEFT  = 3;
    localparam int KEY_RIGHT = 2;
    localparam int KEY_SOFT  = 1;
    localparam int KEY_HARD  = 0;

    logic        clk;
    logic        reset;
    logic [3:0]  keys;
    logic        rotate_mode;
    piece_t      piece_sel;
    logic        restart;
    pose_t       pose;

    pose_t       expected;
    int          exp_row;
    int          exp_col;
    int          exp_orient;
    logic        check_strobe;
    logic [31:0] lfsr;
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;

    tetromino_control #(
        .cooldown_cycles (COOLDOWN)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .keys        (keys),
        .rotate_mode (rotate_mode),
        .piece_sel   (piece_sel),
        .restart     (restart),
        .pose        (pose)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string pose_str(pose_t p);
        return $sformatf("(row %0d, col %0d, orient %0d)", int'(p.row), int'(p.col),
                         int'(p.orient));
    endfunction

    // pose after each press checked in the quiet window
    a_pose_matches_model: assert property (@(posedge clk) disable iff (reset)
        check_strobe |-> pose == expected)
        else begin
            $display("Mismatch in %s: expected %s, actual %s", test_name,
                     pose_str(expected), pose_str(pose));
            errors++;
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // occupied cells of the 4x4 box as one row mask per box row
    function automatic logic [3:0][3:0] box_rows(piece_t piece, int orient);
        logic [3:0][3:0] rows;
        rows = '0;
        if (piece == PIECE_I) begin
            case (orient)
                0:       rows[1] = 4'b1111;
                1:       rows = {4{4'b0100}};
                2:       rows[2] = 4'b1111;
                default: rows = {4{4'b0010}};
            endcase
        end else if (piece == PIECE_T) begin
            rows[0] = (orient == 2) ? 4'b0000 : 4'b0010;
            rows[1] = (orient == 1) ? 4'b0110 : (orient == 3) ? 4'b0011 : 4'b0111;
            rows[2] = (orient == 0) ? 4'b0000 : 4'b0010;
        end else begin
            rows[0] = 4'b0110;
            rows[1] = 4'b0110;
        end
        return rows;
    endfunction

    function automatic logic pose_fits(piece_t piece, int row, int col, int orient);
        logic [3:0][3:0] rows;
        int              rr;
        int              cc;
        rows = box_rows(piece, orient);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rr = row + r;
                cc = col + c;
                if (rows[r][c]) begin
                    if (rr < 0 || rr >= PLAYFIELD_ROWS || cc < 0 || cc >= PLAYFIELD_COLS) begin
                        return 1'b0;
                    end
                    if (LOCKED_FIELD[rr][cc]) begin
                        return 1'b0;
                    end
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic set_model(input int row, input int col, input int orient);
        exp_row    = row;
        exp_col    = col;
        exp_orient = orient;
        expected   = '{row: coord_t'(row), col: coord_t'(col),
                       orient: orientation_t'(orient[1:0])};
    endtask

    // one accepted or refused action on the model pose
    task automatic model_action(input int key);
        int row;
        int col;
        int orient;
        row    = exp_row;
        col    = exp_col;
        orient = exp_orient;
        if (key == KEY_LEFT && rotate_mode) begin
            orient = (orient + 3) % 4;
        end else if (key == KEY_LEFT) begin
            col = col - 1;
        end else if (key == KEY_RIGHT && rotate_mode) begin
            orient = (orient + 1) % 4;
        end else if (key == KEY_RIGHT) begin
            col = col + 1;
        end else if (key == KEY_SOFT) begin
            row = row + 1;
        end else begin
            while (pose_fits(piece_sel, row + 1, col, orient)) begin
                row++;
            end
        end
        if (pose_fits(piece_sel, row, col, orient)) begin
            set_model(row, col, orient);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_pose();
        check_strobe = 1'b1;
        checks++;
        next_cycle();
        check_strobe = 1'b0;
    endtask

    task automatic expect_field(input string what, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("Mismatch in %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // one fire per cooldown+1 cycles while the key stays held
    task automatic press(input int key, input int hold);
        int fires;
        fires     = (hold - 1) / (COOLDOWN + 1) + 1;
        keys[key] = 1'b0;
        repeat (hold) next_cycle();
        keys[key] = 1'b1;
        repeat (fires) model_action(key);
        repeat (IDLE_CYCLES) next_cycle();
        check_pose();
    endtask

    task automatic apply_restart();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
        set_model(SPAWN_ROW, SPAWN_COL, 0);
        next_cycle();
    endtask

    task automatic set_mode(input logic rotate);
        rotate_mode = rotate;
        repeat (4) next_cycle();
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int n;
        int moves;
        int lefts;
        int landed_row;
        reset        = 1'b1;
        keys         = 4'hF;
        rotate_mode  = 1'b0;
        piece_sel    = PIECE_O;
        restart      = 1'b0;
        check_strobe = 1'b0;
        lfsr         = 32'ha7f56df9;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        set_model(SPAWN_ROW, SPAWN_COL, 0);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset");
        check_pose();
        repeat (10) next_cycle();
        check_pose();
        expect_field("row", 0, int'(pose.row));
        expect_field("col", 3, int'(pose.col));
        expect_field("orient", 0, int'(pose.orient));
        finish_test();

        start_test("right_wall");
        apply_restart();
        random_bits(3, n);
        n = n + 1;
        repeat (n) press(KEY_RIGHT, HOLD_CYCLES);
        // O fills box columns 1 and 2
        expect_field("col", (3 + n < PLAYFIELD_COLS - 3) ? 3 + n : PLAYFIELD_COLS - 3,
                     int'(pose.col));
        finish_test();

        start_test("cooldown_repeat");
        apply_restart();
        press(KEY_RIGHT, 10);
        expect_field("col after short hold", 4, int'(pose.col));
        apply_restart();
        // one column left of spawn so the wall cannot hide an extra repeat
        press(KEY_LEFT, HOLD_CYCLES);
        press(KEY_RIGHT, 60);
        moves = (60 - 1) / 17 + 1;
        expect_field("col after long hold", (2 + moves < 7) ? 2 + moves : 7, int'(pose.col));
        finish_test();

        start_test("rotation");
        piece_sel = PIECE_T;
        apply_restart();
        set_mode(1'b1);
        random_bits(2, n);
        random_bits(2, lefts);
        repeat (n + 1) press(KEY_RIGHT, HOLD_CYCLES);
        repeat (lefts + 1) press(KEY_LEFT, HOLD_CYCLES);
        expect_field("orient", ((n - lefts) % 4 + 4) % 4, int'(pose.orient));
        expect_field("row", 0, int'(pose.row));
        expect_field("col", 3, int'(pose.col));
        set_mode(1'b0);
        finish_test();

        start_test("drops");
        random_bits(2, n);
        piece_sel = (n == 0) ? PIECE_I : (n == 1) ? PIECE_O : PIECE_T;
        apply_restart();
        random_bits(3, n);
        repeat (n + 1) press(KEY_SOFT, HOLD_CYCLES);
        expect_field("row after soft drops", n + 1, int'(pose.row));
        piece_sel = PIECE_I;
        apply_restart();
        press(KEY_HARD, HOLD_CYCLES);
        landed_row = exp_row;
        press(KEY_SOFT, HOLD_CYCLES);
        expect_field("row after refused soft drop", landed_row, int'(pose.row));
        finish_test();

        start_test("restart");
        piece_sel = PIECE_O;
        apply_restart();
        random_bits(2, n);
        repeat (n + 1) press(KEY_LEFT, HOLD_CYCLES);
        press(KEY_SOFT, HOLD_CYCLES);
        apply_restart();
        check_pose();
        expect_field("row", 0, int'(pose.row));
        expect_field("col", 3, int'(pose.col));
        expect_field("orient", 0, int'(pose.orient));
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== design/action_gate.sv ====
// one action: cooldown counter and single-cycle pulse
`timescale 1ns/100ps

module action_gate
    import piece_pkg::*;
#(
    parameter int unsigned cooldown_cycles = COOLDOWN_CYCLES
) (
    input  logic clk,
    input  logic reset,
    input  logic trigger,
    input  logic fits,
    output logic pulse
);
    localparam int CNT_W = $clog2(cooldown_cycles + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(cooldown_cycles);

    logic [CNT_W-1:0] count;
    logic             idle;
    logic             fire;

    assign idle = (count == '0);
    assign fire = trigger && !pulse && idle && fits;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pulse <= 1'b0;
            count <= '0;
        end else begin
            pulse <= fire;
            // counter starts with the pulse and wraps back to idle
            if (fire) begin
                count <= CNT_W'(1);
            end else if (count == CNT_LAST) begin
                count <= '0;
            end else if (!idle) begin
                count <= count + 1'b1;
            end
        end
    end

    // a pulse only ever follows an idle counter, and it starts the count
    a_pulse_from_idle: assert property (@(posedge clk) disable iff (reset)
        pulse |-> ($past(count) == '0) && (count != '0 || cooldown_cycles == 0));

endmodule

// ==== design/input_conditioner.sv ====
// key and mode synchronizers, move/rotate steering
// six cooldown gates producing the action pulses
`timescale 1ns/100ps

module input_conditioner
    import piece_pkg::*;
#(
    parameter int unsigned cooldown_cycles = COOLDOWN_CYCLES
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] keys,
    input  logic       rotate_mode,
    input  fit_t       fits,
    output action_t    actions
);
    // keys are active low: [3] left, [2] right, [1] soft drop, [0] hard drop
    logic [3:0] key_meta;
    logic [3:0] key_sync;
    logic       mode_meta;
    logic       mode_sync;
    action_t    trig;
    logic [5:0] gate_fits;
    logic [5:0] pulses;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            key_meta  <= '0;
            key_sync  <= '0;
            mode_meta <= 1'b0;
            mode_sync <= 1'b0;
        end else begin
            key_meta  <= ~keys;
            key_sync  <= key_meta;
            mode_meta <= rotate_mode;
            mode_sync <= mode_meta;
        end
    end

    // left/right feed either the move pair or the rotate pair
    always_comb begin
        trig.rotate_r  = mode_sync && key_sync[2];
        trig.rotate_l  = mode_sync && key_sync[3];
        trig.move_r    = !mode_sync && key_sync[2];
        trig.move_l    = !mode_sync && key_sync[3];
        trig.soft_drop = key_sync[1];
        trig.hard_drop = key_sync[0];
    end

    // same bit order as action_t, hard drop always fits
    assign gate_fits = {fits, 1'b1};

    for (genvar g = 0; g < 6; g++) begin : g_gate
        action_gate #(
            .cooldown_cycles (cooldown_cycles)
        ) u_gate (
            .clk     (clk),
            .reset   (reset),
            .trigger (trig[g]),
            .fits    (gate_fits[g]),
            .pulse   (pulses[g])
        );
    end

    assign actions = action_t'(pulses);

    a_move_rotate_excl: assert property (@(posedge clk) disable iff (reset)
        !((actions.move_r || actions.move_l) && (actions.rotate_r || actions.rotate_l)));

endmodule

// ==== design/move_validator.sv ====
// candidate poses for every action and their fit flags
// hard drop landing search over all row offsets
`timescale 1ns/100ps

module move_validator
    import piece_pkg::*;
(
    input  piece_t piece,
    input  pose_t  current,
    output fit_t   fits,
    output pose_t  rotate_r_pose,
    output pose_t  rotate_l_pose,
    output pose_t  move_r_pose,
    output pose_t  move_l_pose,
    output pose_t  soft_drop_pose,
    output pose_t  hard_drop_pose
);
    pose_t [4:0]               action_cand;
    logic  [4:0]               action_fit;
    pose_t                     drop_cand [PLAYFIELD_ROWS];
    logic  [PLAYFIELD_ROWS-1:0] drop_fit;

    always_comb begin
        rotate_r_pose        = current;
        rotate_r_pose.orient = orientation_t'(current.orient + 2'd1);
        rotate_l_pose        = current;
        rotate_l_pose.orient = orientation_t'(current.orient - 2'd1);
        move_r_pose          = current;
        move_r_pose.col      = current.col + 6'sd1;
        move_l_pose          = current;
        move_l_pose.col      = current.col - 6'sd1;
        soft_drop_pose       = current;
        soft_drop_pose.row   = current.row + 6'sd1;
    end

    // index order follows fit_t, soft drop in bit 0
    assign action_cand = {rotate_r_pose, rotate_l_pose, move_r_pose,
                          move_l_pose, soft_drop_pose};

    for (genvar a = 0; a < 5; a++) begin : g_action_fit
        piece_fit u_fit (
            .piece (piece),
            .cand  (action_cand[a]),
            .fits  (action_fit[a])
        );
    end

    assign fits = fit_t'(action_fit);

    // drop_cand[d] is the pose d+1 rows further down
    for (genvar d = 0; d < PLAYFIELD_ROWS; d++) begin : g_drop_fit
        assign drop_cand[d] = '{
            row:    current.row + coord_t'(d + 1),
            col:    current.col,
            orient: current.orient
        };

        piece_fit u_fit (
            .piece (piece),
            .cand  (drop_cand[d]),
            .fits  (drop_fit[d])
        );
    end

    // deepest offset reached without a gap in the fit chain
    always_comb begin
        logic reach;
        reach          = 1'b1;
        hard_drop_pose = current;
        for (int d = 0; d < PLAYFIELD_ROWS; d++) begin
            reach = reach && drop_fit[d];
            if (reach) begin
                hard_drop_pose = drop_cand[d];
            end
        end
    end

endmodule

// ==== design/piece_fit.sv ====
// collision check of one candidate pose
// against walls, floor and locked cells
`timescale 1ns/100ps

module piece_fit
    import piece_pkg::*;
(
    input  piece_t piece,
    input  pose_t  cand,
    output logic   fits
);
    shape_t shape;

    assign shape = shape_cells(piece, cand.orient);

    always_comb begin
        coord_t row;
        coord_t col;
        fits = 1'b1;
        for (int i = 0; i < 4; i++) begin
            row = cand.row + coord_t'({4'b0000, shape[i].row});
            col = cand.col + coord_t'({4'b0000, shape[i].col});
            if (row < 0 || row >= PLAYFIELD_ROWS) begin
                fits = 1'b0;
            end else if (col < 0 || col >= PLAYFIELD_COLS) begin
                fits = 1'b0;
            end else if (LOCKED_FIELD[row[4:0]][col[3:0]]) begin
                // only indexed once the cell is known to be on the field
                fits = 1'b0;
            end
        end
    end

endmodule

// ==== design/piece_pkg.sv ====
// playfield size, cooldown default and coordinate types
// pose, action and fit structs, spawn pose
// locked cell pattern and tetromino shape table
package piece_pkg;

    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;

    localparam int unsigned COOLDOWN_CYCLES = 10_000_000;

    // signed so that a step past an edge stays visible
    typedef logic signed [5:0] coord_t;

    typedef enum logic [1:0] {
        ORIENT_0,
        ORIENT_R,
        ORIENT_2,
        ORIENT_L
    } orientation_t;

    typedef enum logic [2:0] {
        PIECE_I,
        PIECE_O,
        PIECE_T,
        PIECE_J,
        PIECE_L,
        PIECE_S,
        PIECE_Z
    } piece_t;

    typedef struct packed {
        coord_t       row;
        coord_t       col;
        orientation_t orient;
    } pose_t;

    typedef struct packed {
        logic rotate_r;
        logic rotate_l;
        logic move_r;
        logic move_l;
        logic soft_drop;
        logic hard_drop;
    } action_t;

    // hard drop always succeeds, so no flag for it
    typedef struct packed {
        logic rotate_r;
        logic rotate_l;
        logic move_r;
        logic move_l;
        logic soft_drop;
    } fit_t;

    // one cell offset inside the 4x4 box
    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
    } cell_t;

    typedef cell_t [3:0] shape_t;

    localparam pose_t SPAWN_POSE = '{row: 6'sd0, col: 6'sd3, orient: ORIENT_0};

    // rows 17 to 19 hold a J, an S and an L; bit index is the column
    localparam logic [PLAYFIELD_ROWS-1:0][PLAYFIELD_COLS-1:0] LOCKED_FIELD = {
        10'b01_1101_1100,
        10'b01_1100_0100,
        10'b01_1000_0000,
        {17{10'b00_0000_0000}}
    };

    // each hex digit is one cell, row in the upper two bits
    function automatic shape_t shape_cells(piece_t piece, orientation_t orient);
        shape_t cells;
        cells = 16'h1256;
        case (piece)
            PIECE_I: begin
                case (orient)
                    ORIENT_0: cells = 16'h4567;
                    ORIENT_R: cells = 16'h26AE;
                    ORIENT_2: cells = 16'h89AB;
                    default:  cells = 16'h159D;
                endcase
            end
            PIECE_T: begin
                case (orient)
                    ORIENT_0: cells = 16'h1456;
                    ORIENT_R: cells = 16'h1569;
                    ORIENT_2: cells = 16'h4569;
                    default:  cells = 16'h1459;
                endcase
            end
            PIECE_J: begin
                case (orient)
                    ORIENT_0: cells = 16'h0456;
                    ORIENT_R: cells = 16'h1259;
                    ORIENT_2: cells = 16'h456A;
                    default:  cells = 16'h1589;
                endcase
            end
            PIECE_L: begin
                case (orient)
                    ORIENT_0: cells = 16'h2456;
                    ORIENT_R: cells = 16'h159A;
                    ORIENT_2: cells = 16'h4568;
                    default:  cells = 16'h0159;
                endcase
            end
            PIECE_S: begin
                case (orient)
                    ORIENT_0: cells = 16'h1245;
                    ORIENT_R: cells = 16'h156A;
                    ORIENT_2: cells = 16'h5689;
                    default:  cells = 16'h0459;
                endcase
            end
            PIECE_Z: begin
                case (orient)
                    ORIENT_0: cells = 16'h0156;
                    ORIENT_R: cells = 16'h2569;
                    ORIENT_2: cells = 16'h459A;
                    default:  cells = 16'h1458;
                endcase
            end
            // O and the unused code share the square
            default: cells = 16'h1256;
        endcase
        return cells;
    endfunction

endpackage

// ==== design/pose_register.sv ====
// action priority select and the registered falling pose
`timescale 1ns/100ps

module pose_register
    import piece_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    restart,
    input  action_t actions,
    input  pose_t   rotate_r_pose,
    input  pose_t   rotate_l_pose,
    input  pose_t   move_r_pose,
    input  pose_t   move_l_pose,
    input  pose_t   soft_drop_pose,
    input  pose_t   hard_drop_pose,
    output pose_t   pose
);
    pose_t next_pose;
    logic  any_action;

    assign any_action = |actions;

    // hard drop first, rotation last
    always_comb begin
        next_pose = pose;
        if (actions.hard_drop) begin
            next_pose = hard_drop_pose;
        end else if (actions.soft_drop) begin
            next_pose = soft_drop_pose;
        end else if (actions.move_r) begin
            next_pose = move_r_pose;
        end else if (actions.move_l) begin
            next_pose = move_l_pose;
        end else if (actions.rotate_r) begin
            next_pose = rotate_r_pose;
        end else if (actions.rotate_l) begin
            next_pose = rotate_l_pose;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pose <= SPAWN_POSE;
        end else if (restart) begin
            pose <= SPAWN_POSE;
        end else if (any_action) begin
            pose <= next_pose;
        end
    end

    a_pose_needs_cause: assert property (@(posedge clk) disable iff (reset)
        !$stable(pose) |-> $past(any_action || restart));

endmodule

// ==== design/tetromino_control.sv ====
// top level of the falling piece control core
// conditioner, validator and pose register
`timescale 1ns/100ps

module tetromino_control
    import piece_pkg::*;
#(
    parameter int unsigned cooldown_cycles = COOLDOWN_CYCLES
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] keys,
    input  logic       rotate_mode,
    input  piece_t     piece_sel,
    input  logic       restart,
    output pose_t      pose
);
    action_t actions;
    fit_t    fits;
    pose_t   rotate_r_pose;
    pose_t   rotate_l_pose;
    pose_t   move_r_pose;
    pose_t   move_l_pose;
    pose_t   soft_drop_pose;
    pose_t   hard_drop_pose;

    input_conditioner #(
        .cooldown_cycles (cooldown_cycles)
    ) u_cond (
        .clk         (clk),
        .reset       (reset),
        .keys        (keys),
        .rotate_mode (rotate_mode),
        .fits        (fits),
        .actions     (actions)
    );

    move_validator u_valid (
        .piece          (piece_sel),
        .current        (pose),
        .fits           (fits),
        .rotate_r_pose  (rotate_r_pose),
        .rotate_l_pose  (rotate_l_pose),
        .move_r_pose    (move_r_pose),
        .move_l_pose    (move_l_pose),
        .soft_drop_pose (soft_drop_pose),
        .hard_drop_pose (hard_drop_pose)
    );

    pose_register u_pose (
        .clk            (clk),
        .reset          (reset),
        .restart        (restart),
        .actions        (actions),
        .rotate_r_pose  (rotate_r_pose),
        .rotate_l_pose  (rotate_l_pose),
        .move_r_pose    (move_r_pose),
        .move_l_pose    (move_l_pose),
        .soft_drop_pose (soft_drop_pose),
        .hard_drop_pose (hard_drop_pose),
        .pose           (pose)
    );

endmodule

// ==== tetromino_control.f ====
design/piece_pkg.sv
design/action_gate.sv
design/piece_fit.sv
design/input_conditioner.sv
design/move_validator.sv
design/pose_register.sv
design/tetromino_control.sv
bench/tb_tetromino_control.sv
